//--- source/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int EE_ADDR_W = 11;
    localparam logic [3:0] DEV_TYPE = 4'b1010;  // 24Cxx device type

    typedef enum logic [2:0] {
        OP_START,
        OP_RESTART,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } i2c_op_e;

    typedef struct packed {
        logic [3:0] dev_type;
        logic [2:0] block;      // addr bits 10:8
        logic       rnw;
    } ctrl_byte_t;

    // same wire byte, seen as control byte or as plain data
    typedef union packed {
        ctrl_byte_t ctrl;
        logic [7:0] raw;
    } i2c_byte_u;

    typedef struct packed {
        i2c_op_e   op;
        i2c_byte_u data;
        logic      master_ack;  // 1 = ack after a read byte
    } i2c_op_t;

    typedef struct packed {
        logic [7:0] data;
        logic       slave_nack;
    } i2c_res_t;

endpackage

`default_nettype wire

//--- source/axil_pkg.sv
`default_nettype none

package axil_pkg;

    typedef struct packed {
        logic [3:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [3:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

    localparam logic [3:0] REG_CMD    = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    typedef struct packed {
        logic [7:0]  rsvd_hi;
        logic [7:0]  wdata;
        logic [2:0]  rsvd_mid;
        logic        rd;        // 1 = random read, 0 = byte write
        logic        rsvd_lo;
        logic [10:0] addr;
    } cmd_t;

    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  rdata;
        logic [4:0]  rsvd_lo;
        logic        nack;
        logic        done;
        logic        busy;
    } status_t;

endpackage

`default_nettype wire

//--- source/i2c_bit_engine.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_bit_engine #(
    parameter int SCL_DIV = 2
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 op_valid,
    input  eeprom_pkg::i2c_op_t  op,
    output logic                 op_ready,
    output logic                 res_valid,
    output eeprom_pkg::i2c_res_t res,
    output logic                 scl,
    output logic                 sda_pull,
    input  logic                 sda_in
);
    import eeprom_pkg::*;

    localparam int QW = $clog2(SCL_DIV + 1);

    logic          active;
    i2c_op_t       op_q;
    logic [QW-1:0] qcnt;
    logic [1:0]    quarter;
    logic [3:0]    bit_cnt;     // 8 = ack slot
    logic [7:0]    shreg;
    logic          ack_nack;
    logic          tick;
    logic          byte_op;
    logic          last_bit;
    logic          scl_nxt;
    logic          pull_nxt;

    assign op_ready = !active;
    assign tick     = active && (qcnt == QW'(SCL_DIV - 1));
    assign byte_op  = (op_q.op == OP_WRITE) || (op_q.op == OP_READ);
    assign last_bit = byte_op ? (bit_cnt == 4'd8) : 1'b1;
    assign res      = '{data: shreg, slave_nack: ack_nack};

    // line levels per quarter, registered below
    always_comb
    begin
        scl_nxt  = scl;
        pull_nxt = sda_pull;
        if (active)
        begin
            case (op_q.op)
                OP_START, OP_RESTART:
                begin
                    scl_nxt  = (quarter == 2'd0) ? scl : (quarter != 2'd3);
                    pull_nxt = quarter[1];  // falls while scl high
                end
                OP_STOP:
                begin
                    scl_nxt  = (quarter != 2'd0);
                    pull_nxt = (quarter < 2'd2);  // rises while scl high
                end
                default:
                begin
                    scl_nxt = (quarter == 2'd1) || (quarter == 2'd2);
                    if (bit_cnt == 4'd8)
                        pull_nxt = (op_q.op == OP_READ) && op_q.master_ack;
                    else
                        pull_nxt = (op_q.op == OP_WRITE) && !shreg[7];
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active    <= 1'b0;
            res_valid <= 1'b0;
            scl       <= 1'b1;
            sda_pull  <= 1'b0;
            qcnt      <= '0;
            quarter   <= 2'd0;
            bit_cnt   <= 4'd0;
        end
        else
        begin
            res_valid <= 1'b0;
            scl       <= scl_nxt;
            sda_pull  <= pull_nxt;
            if (!active)
            begin
                if (op_valid)
                begin
                    active  <= 1'b1;
                    qcnt    <= '0;
                    quarter <= 2'd0;
                    bit_cnt <= 4'd0;
                end
            end
            else if (tick)
            begin
                qcnt    <= '0;
                quarter <= quarter + 2'd1;
                if (quarter == 2'd3)
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (last_bit)
                    begin
                        active    <= 1'b0;
                        res_valid <= 1'b1;
                    end
                end
            end
            else
                qcnt <= qcnt + 1'b1;
        end
    end

    // shifter, sampled at the end of the second high quarter
    always_ff @(posedge CLK)
    begin
        if (!active && op_valid)
        begin
            op_q     <= op;
            shreg    <= op.data.raw;
            ack_nack <= 1'b0;
        end
        else if (tick && byte_op)
        begin
            if (quarter == 2'd2 && bit_cnt == 4'd8 && op_q.op == OP_WRITE)
                ack_nack <= sda_in;
            else if (quarter == 2'd2 && bit_cnt != 4'd8 && op_q.op == OP_READ)
                shreg <= {shreg[6:0], sda_in};
            else if (quarter == 2'd3 && op_q.op == OP_WRITE)
                shreg <= {shreg[6:0], 1'b0};  // msb first
        end
    end

endmodule

`default_nettype wire

//--- source/eeprom_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_sequencer (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 start,
    input  axil_pkg::cmd_t       cmd,
    output logic                 busy,
    output logic                 done,
    output logic                 nack,
    output logic [7:0]           rdata,
    output logic                 op_valid,
    output eeprom_pkg::i2c_op_t  op,
    input  logic                 op_ready,
    input  logic                 res_valid,
    input  eeprom_pkg::i2c_res_t res
);
    import eeprom_pkg::*;
    import axil_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RESTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP
    } state_e;

    state_e               state;
    state_e               state_nxt;
    cmd_t                 cmd_q;
    logic [EE_ADDR_W-1:0] ee_addr;
    i2c_byte_u            ctrl;
    logic                 got_nack;

    assign busy     = (state != S_IDLE);
    assign ee_addr  = cmd_q.addr;
    assign got_nack = res.slave_nack && (op.op == OP_WRITE);

    always_comb
    begin
        ctrl.ctrl.dev_type = DEV_TYPE;
        ctrl.ctrl.block    = ee_addr[EE_ADDR_W-1 -: 3];
        ctrl.ctrl.rnw      = (state == S_CTRL_R);
        op.op         = OP_WRITE;
        op.data       = ctrl;
        op.master_ack = 1'b0;  // single byte read ends with nack
        case (state)
            S_START:   op.op = OP_START;
            S_RESTART: op.op = OP_RESTART;
            S_STOP:    op.op = OP_STOP;
            S_ADDR:    op.data.raw = ee_addr[7:0];
            S_DATA_W:  op.data.raw = cmd_q.wdata;
            S_DATA_R:  op.op = OP_READ;
            default:   op.op = OP_WRITE;
        endcase
    end

    always_comb
    begin
        case (state)
            S_START:   state_nxt = S_CTRL_W;
            S_CTRL_W:  state_nxt = S_ADDR;
            S_ADDR:    state_nxt = cmd_q.rd ? S_RESTART : S_DATA_W;
            S_RESTART: state_nxt = S_CTRL_R;
            S_CTRL_R:  state_nxt = S_DATA_R;
            S_DATA_W, S_DATA_R: state_nxt = S_STOP;
            default:   state_nxt = S_IDLE;
        endcase
        if (got_nack)
            state_nxt = S_STOP;  // release the bus right away
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            op_valid <= 1'b0;
            done     <= 1'b0;
            nack     <= 1'b0;
            rdata    <= 8'd0;
        end
        else
        begin
            done <= 1'b0;
            if (op_valid && op_ready)
                op_valid <= 1'b0;
            if (state == S_IDLE)
            begin
                if (start)
                begin
                    state    <= S_START;
                    op_valid <= 1'b1;
                    nack     <= 1'b0;
                end
            end
            else if (res_valid)
            begin
                state    <= state_nxt;
                op_valid <= (state_nxt != S_IDLE);
                if (got_nack)
                    nack <= 1'b1;
                if (state == S_DATA_R)
                    rdata <= res.data;
                if (state == S_STOP)
                    done <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start && !busy)
            cmd_q <= cmd;
    end

endmodule

`default_nettype wire

//--- source/axil_regs.sv
`timescale 1ns/1ns
`default_nettype none

module axil_regs (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               aw_valid,
    input  logic               w_valid,
    input  logic               b_ready,
    input  logic               ar_valid,
    input  logic               r_ready,
    input  axil_pkg::axil_aw_t aw,
    input  axil_pkg::axil_w_t  w,
    input  axil_pkg::axil_ar_t ar,
    output logic               aw_ready,
    output logic               w_ready,
    output logic               b_valid,
    output logic               ar_ready,
    output logic               r_valid,
    output axil_pkg::axil_b_t  b,
    output axil_pkg::axil_r_t  r,
    output logic               start,
    output axil_pkg::cmd_t     cmd,
    input  logic               busy,
    input  logic               done,
    input  logic               nack,
    input  logic [7:0]         rdata
);
    import axil_pkg::*;

    logic        wr_rdy;
    logic        wr_hs;
    logic        rd_hs;
    logic        cmd_hit;
    logic [31:0] cmd_word;
    cmd_t        cmd_q;
    status_t     status;
    logic        done_q;
    logic        nack_q;
    logic [7:0]  rdata_q;

    assign aw_ready = wr_rdy;
    assign w_ready  = wr_rdy;
    assign wr_hs    = aw_valid && aw_ready && w_valid && w_ready;
    assign rd_hs    = ar_valid && ar_ready;
    assign cmd_hit  = (aw.addr == REG_CMD);
    assign start    = wr_hs && cmd_hit && !busy;  // busy: command dropped
    assign cmd      = cmd_t'(cmd_word);

    // byte lanes merge over the last command
    always_comb
    begin
        for (int i = 0; i < 4; i++)
            cmd_word[8*i +: 8] = w.strb[i] ? w.data[8*i +: 8] : cmd_q[8*i +: 8];
    end

    always_comb
    begin
        status       = '0;
        status.rdata = rdata_q;
        status.nack  = nack_q;
        status.done  = done_q;
        status.busy  = busy;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_rdy   <= 1'b0;
            b_valid  <= 1'b0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            done_q   <= 1'b0;
            nack_q   <= 1'b0;
            rdata_q  <= 8'd0;
        end
        else
        begin
            wr_rdy   <= aw_valid && w_valid && !wr_rdy && !b_valid;
            ar_ready <= ar_valid && !ar_ready && !r_valid;
            if (wr_hs)
                b_valid <= 1'b1;
            else if (b_ready)
                b_valid <= 1'b0;
            if (rd_hs)
                r_valid <= 1'b1;
            else if (r_ready)
                r_valid <= 1'b0;
            if (done)
            begin
                done_q  <= 1'b1;
                nack_q  <= nack;
                rdata_q <= rdata;
            end
            if (start)
                done_q <= 1'b0;  // new command wins
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wr_hs)
            b.resp <= (cmd_hit && !busy) ? RESP_OKAY : RESP_SLVERR;
        if (start)
            cmd_q <= cmd;
        if (rd_hs)
        begin
            r.data <= (ar.addr == REG_STATUS) ? status : 32'd0;
            r.resp <= (ar.addr == REG_STATUS) ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

//--- source/eeprom_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_ctrl_top #(
    parameter int SCL_DIV = 2  // clocks per quarter scl
) (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               aw_valid,
    input  logic               w_valid,
    input  logic               b_ready,
    input  logic               ar_valid,
    input  logic               r_ready,
    input  axil_pkg::axil_aw_t aw,
    input  axil_pkg::axil_w_t  w,
    input  axil_pkg::axil_ar_t ar,
    output logic               aw_ready,
    output logic               w_ready,
    output logic               b_valid,
    output logic               ar_ready,
    output logic               r_valid,
    output axil_pkg::axil_b_t  b,
    output axil_pkg::axil_r_t  r,
    output logic               scl,
    output logic               sda_pull,
    input  logic               sda_in
);
    import axil_pkg::*;
    import eeprom_pkg::*;

    logic       start;
    cmd_t       cmd;
    logic       busy;
    logic       done;
    logic       nack;
    logic [7:0] rdata;

    logic       op_valid;
    logic       op_ready;
    i2c_op_t    op;
    logic       res_valid;
    i2c_res_t   res;

    axil_regs u_regs (.*);

    eeprom_sequencer u_seq (.*);

    i2c_bit_engine #(
        .SCL_DIV(SCL_DIV)
    ) u_engine (.*);

endmodule

`default_nettype wire

//--- test/eeprom_model.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_model (
    input  logic scl,
    input  logic sda,
    output logic pull
);
    import eeprom_pkg::*;

    logic [7:0] mem [0:2047];
    logic       scl_q;
    logic       sda_q;
    logic       active;
    logic       tx_pending;
    logic       tx_mode;
    logic [3:0] cnt;        // scl rises seen in this byte
    logic [1:0] byte_idx;
    logic [7:0] shreg;
    logic [7:0] tx_byte;
    logic [2:0] block;
    logic [7:0] word;
    i2c_byte_u  rx;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;
        active     = 1'b0;
        pull       = 1'b0;
        tx_pending = 1'b0;
        tx_mode    = 1'b0;
        cnt        = 4'd0;
        byte_idx   = 2'd0;
        block      = 3'd0;
        word       = 8'd0;
    end

    // control byte first, then word address, then data
    task accept_byte();
        rx.raw = shreg;
        case (byte_idx)
            2'd0:
            begin
                pull = (rx.ctrl.dev_type == DEV_TYPE);
                block = rx.ctrl.block;
                if (pull && rx.ctrl.rnw)
                begin
                    tx_pending = 1'b1;
                    tx_byte    = mem[{block, word}];
                end
            end
            2'd1:
            begin
                word = rx.raw;
                pull = 1'b1;
            end
            default:
            begin
                pull = ({block, word} < 11'h7f0);  // top page is read only
                if (pull)
                    mem[{block, word}] = rx.raw;
            end
        endcase
        if (byte_idx != 2'd3)
            byte_idx = byte_idx + 2'd1;
    endtask

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
        begin
            active     = (sda === 1'b0);  // start or stop
            cnt        = 4'd0;
            byte_idx   = 2'd0;
            tx_pending = 1'b0;
            tx_mode    = 1'b0;
        end
        else if (active && scl === 1'b1 && scl_q === 1'b0)
        begin
            if (cnt < 4'd8)
                shreg = {shreg[6:0], sda};
            cnt = cnt + 4'd1;
        end
        else if (active && scl === 1'b0 && scl_q === 1'b1)
        begin
            if (cnt == 4'd8)
            begin
                if (tx_mode)
                begin
                    pull    = 1'b0;  // master acks here
                    tx_mode = 1'b0;
                end
                else
                    accept_byte();
            end
            else if (cnt == 4'd9)
            begin
                cnt  = 4'd0;
                pull = 1'b0;
                if (tx_pending)
                begin
                    tx_pending = 1'b0;
                    tx_mode    = 1'b1;
                    pull       = !tx_byte[7];
                end
            end
            else if (tx_mode && cnt != 4'd0)
            begin
                tx_byte = {tx_byte[6:0], 1'b0};
                pull    = !tx_byte[7];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

//--- test/eeprom_ctrl_props.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_ctrl_props (
    input logic                CLK,
    input logic                RESET,
    input logic                b_valid,
    input logic                b_ready,
    input axil_pkg::axil_b_t   b,
    input logic                r_valid,
    input logic                r_ready,
    input axil_pkg::axil_r_t   r,
    input logic                aw_ready,
    input logic                w_ready,
    input logic                ar_ready,
    input logic                busy,
    input logic                scl,
    input logic                sda_in,
    input eeprom_pkg::i2c_op_e engine_op  // op the bit engine is running
);
    import eeprom_pkg::*;

    b_hold: assert property (@(posedge CLK) disable iff (RESET)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else $error("write response dropped or changed before bready");

    r_hold: assert property (@(posedge CLK) disable iff (RESET)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("read response dropped or changed before rready");

    // with scl high only the master's start or stop may move sda
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && (sda_in != $past(sda_in))
        |-> $past(engine_op) inside {OP_START, OP_RESTART, OP_STOP})
        else $error("sda changed while scl high outside start or stop");

    reset_idle: assert property (@(posedge CLK)
        RESET |=> !busy && !aw_ready && !w_ready && !ar_ready)
        else $error("busy or ready high after reset");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_props props (
    .CLK(CLK), .RESET(RESET), .b_valid(b_valid), .b_ready(b_ready), .b(b),
    .r_valid(r_valid), .r_ready(r_ready), .r(r), .aw_ready(aw_ready),
    .w_ready(w_ready), .ar_ready(ar_ready), .busy(busy), .scl(scl),
    .sda_in(sda_in), .engine_op(u_engine.op_q.op)
);

`default_nettype wire

//--- test/eeprom_ctrl_tb.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_ctrl_tb;
    import axil_pkg::*;

    localparam int TIMEOUT = 40000;  // ~50 transactions of ~350 cycles, with margin

    logic     CLK;
    logic     RESET;
    logic     aw_valid;
    logic     w_valid;
    logic     b_ready;
    logic     ar_valid;
    logic     r_ready;
    axil_aw_t aw;
    axil_w_t  w;
    axil_ar_t ar;
    logic     aw_ready;
    logic     w_ready;
    logic     b_valid;
    logic     ar_ready;
    logic     r_valid;
    axil_b_t  b;
    axil_r_t  r;
    logic     scl;
    logic     sda_pull;
    logic     sda_in;
    logic     model_pull;

    logic [7:0]  shadow [0:2047];
    logic [31:0] seed;
    int          b_hold;
    int          r_hold;
    int          cycles;

    assign sda_in = !(sda_pull || model_pull);  // pull-up, wired-and

    eeprom_ctrl_top #(
        .SCL_DIV(2)
    ) dut (.*);

    eeprom_model model (
        .scl (scl),
        .sda (sda_in),
        .pull(model_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else
        begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic axi_write(input logic [3:0] offset, input logic [31:0] data,
                             output logic [1:0] resp);
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        aw.addr  = offset;
        w.data   = data;
        w.strb   = 4'hf;
        while (!aw_ready)
            @(negedge CLK);
        @(negedge CLK);
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        while (!b_valid)
            @(negedge CLK);
        resp = b.resp;
        for (int i = 0; i < b_hold; i++)
        begin
            @(negedge CLK);
            check_value("bvalid held", 32'd1, 32'(b_valid));
            check_value("bresp held", 32'(resp), 32'(b.resp));
        end
        b_ready = 1'b1;
        @(negedge CLK);
        b_ready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] offset, output logic [31:0] data,
                            output logic [1:0] resp);
        ar_valid = 1'b1;
        ar.addr  = offset;
        while (!ar_ready)
            @(negedge CLK);
        @(negedge CLK);
        ar_valid = 1'b0;
        while (!r_valid)
            @(negedge CLK);
        repeat (r_hold)
            @(negedge CLK);  // response must survive the stall
        data    = r.data;
        resp    = r.resp;
        r_ready = 1'b1;
        @(negedge CLK);
        r_ready = 1'b0;
    endtask

    task automatic wait_done(output status_t st);
        logic [31:0] d;
        logic [1:0]  resp;
        do
        begin
            axi_read(REG_STATUS, d, resp);
            check_value("status resp", 32'(RESP_OKAY), 32'(resp));
            st = status_t'(d);
        end
        while (!st.done);
    endtask

    task automatic ee_write(input logic [10:0] addr, input logic [7:0] data);
        cmd_t        c;
        logic [1:0]  resp;
        status_t     st;
        logic        exp_nack;
        c        = '0;
        c.addr   = addr;
        c.wdata  = data;
        exp_nack = (addr >= 11'h7f0);
        axi_write(REG_CMD, c, resp);
        check_value("write cmd resp", 32'(RESP_OKAY), 32'(resp));
        wait_done(st);
        check_value("write nack", 32'(exp_nack), 32'(st.nack));
        if (!exp_nack)
            shadow[addr] = data;
    endtask

    task automatic ee_read_check(input string name, input logic [10:0] addr);
        cmd_t       c;
        logic [1:0] resp;
        status_t    st;
        c      = '0;
        c.addr = addr;
        c.rd   = 1'b1;
        axi_write(REG_CMD, c, resp);
        check_value("read cmd resp", 32'(RESP_OKAY), 32'(resp));
        wait_done(st);
        check_value(name, 32'(shadow[addr]), 32'(st.rdata));
        check_value("read nack", 32'd0, 32'(st.nack));
    endtask

    initial
    begin
        logic [31:0] d;
        logic [1:0]  resp;
        logic [10:0] addr;
        cmd_t        c;
        status_t     st;
        RESET    = 1'b1;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        aw       = '0;
        w        = '0;
        ar       = '0;
        b_hold   = 0;
        r_hold   = 0;
        cycles   = 0;
        seed     = 32'h9316;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hff;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        // reset state
        axi_read(REG_STATUS, d, resp);
        check_value("reset status", 32'd0, d);
        check_value("reset status resp", 32'(RESP_OKAY), 32'(resp));
        check_value("idle scl", 32'd1, 32'(scl));
        check_value("idle sda_pull", 32'd0, 32'(sda_pull));

        ee_write(11'h123, 8'h5a);
        ee_read_check("fixed readback", 11'h123);

        for (int i = 0; i < 20; i++)
        begin
            seed = xorshift32(seed);
            addr = {i[2:0], seed[7:0]};  // walk all blocks
            ee_write(addr, seed[15:8]);
            ee_read_check("random readback", addr);
        end

        ee_write(11'h7f5, 8'h33);
        ee_read_check("protected readback", 11'h7f5);

        // second command while the first one runs
        c       = '0;
        c.addr  = 11'h200;
        c.wdata = 8'ha5;
        axi_write(REG_CMD, c, resp);
        check_value("first cmd resp", 32'(RESP_OKAY), 32'(resp));
        c.wdata = 8'h11;
        axi_write(REG_CMD, c, resp);
        check_value("busy cmd resp", 32'(RESP_SLVERR), 32'(resp));
        wait_done(st);
        shadow[11'h200] = 8'ha5;
        ee_read_check("busy readback", 11'h200);
        axi_write(4'h8, 32'h1234, resp);
        check_value("unmapped write resp", 32'(RESP_SLVERR), 32'(resp));
        axi_read(4'hc, d, resp);
        check_value("unmapped read resp", 32'(RESP_SLVERR), 32'(resp));
        check_value("unmapped read data", 32'd0, d);

        // held bready and rready, transfer runs underneath
        b_hold = 10;
        r_hold = 10;
        ee_write(11'h456, 8'hc3);
        b_hold = 0;
        r_hold = 0;
        ee_read_check("stalled bready readback", 11'h456);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- eeprom_ctrl_top.f
source/eeprom_pkg.sv
source/axil_pkg.sv
source/i2c_bit_engine.sv
source/eeprom_sequencer.sv
source/axil_regs.sv
source/eeprom_ctrl_top.sv
test/eeprom_model.sv
test/eeprom_ctrl_props.sv
test/eeprom_ctrl_tb.sv

//--- Makefile
TOP = eeprom_ctrl_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f eeprom_ctrl_top.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir
